// ==== hw/buf_mgr_cfg.svh ====
// Buffer manager sizes
`ifndef BUF_MGR_CFG_SVH
`define BUF_MGR_CFG_SVH

// Shared buffer pool.
`define BM_NUM_BUFS 16
`define BM_PTR_NBITS 4

// Output queues.
`define BM_NUM_QUEUES 4
`define BM_QID_NBITS 2

// Link statistics counters.
`define BM_COUNT_NBITS 16

`endif

// ==== hw/buf_mgr_pkg.sv ====
// Buffer manager types
`include "buf_mgr_cfg.svh"

package buf_mgr_pkg;

	typedef logic [`BM_PTR_NBITS-1:0] buf_ptr_t; // Index into the buffer pool.
	typedef logic [`BM_QID_NBITS-1:0] qid_t; // Queue index.
	typedef logic [`BM_PTR_NBITS:0] free_cnt_t; // One extra bit to hold a full pool.

	typedef enum logic {
		OP_ENQ, // Allocate and append.
		OP_DEQ // Pop head and release.
	} bm_op_e;

	typedef enum logic [1:0] {
		ST_OK,
		ST_FULL, // No free buffer.
		ST_EMPTY // Queue holds nothing.
	} bm_status_e;

	typedef enum logic [2:0] {
		S_IDLE, // Waiting for a command.
		S_ALLOC, // Pop a free pointer.
		S_LINK, // Link behind tail.
		S_READ, // Release head, issue link read.
		S_WAIT, // Wait for link data.
		S_RESP // Present response.
	} ctrl_state_e;

endpackage

// ==== hw/buf_mgr_if.sv ====
// Link table and free list interfaces
`timescale 1ns/10ps

interface link_if;
	import buf_mgr_pkg::*;

	logic enq_valid; // Write "next of cur is nxt".
	buf_ptr_t enq_ptr_cur;
	buf_ptr_t enq_ptr_nxt;
	logic req; // Read "next of req_ptr".
	buf_ptr_t req_ptr;
	logic ack_valid; // Read data returned.
	buf_ptr_t ack_ptr;

	modport ctrl (output enq_valid, enq_ptr_cur, enq_ptr_nxt, req, req_ptr,
		input ack_valid, ack_ptr);
	modport tbl (input enq_valid, enq_ptr_cur, enq_ptr_nxt, req, req_ptr,
		output ack_valid, ack_ptr);
endinterface

interface free_if;
	import buf_mgr_pkg::*;

	logic alloc_valid; // A free pointer is on offer.
	buf_ptr_t alloc_ptr;
	logic alloc_take; // One-cycle pop.
	logic release_valid; // Return a pointer, never refused.
	buf_ptr_t release_ptr;

	modport ctrl (input alloc_valid, alloc_ptr, output alloc_take, release_valid, release_ptr);
	modport pool (output alloc_valid, alloc_ptr, input alloc_take, release_valid, release_ptr);
endinterface

// ==== hw/link_ram.sv ====
// Next-pointer RAM
`timescale 1ns/10ps

module link_ram #(
	parameter int WIDTH = 4,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic wr,
	input logic [$clog2(DEPTH)-1:0] waddr,
	input logic [$clog2(DEPTH)-1:0] raddr,
	input logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] mem [DEPTH]; // One entry per buffer.

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din; // Synchronous write.
		end
	end

	// Registered read, old data on address collision.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

// ==== hw/link_table.sv ====
// Buffer link table
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module link_table (
	input logic clk,
	input logic rst_n,
	link_if.tbl lnk,
	output logic [`BM_COUNT_NBITS-1:0] link_wr_count,
	output logic [`BM_COUNT_NBITS-1:0] link_rd_count
);
	import buf_mgr_pkg::*;

	logic enq_valid_d1; // Write request stage.
	buf_ptr_t enq_cur_d1;
	buf_ptr_t enq_nxt_d1;
	logic req_d1; // Read request stage.
	logic req_d2; // Lines up with RAM output.
	buf_ptr_t req_ptr_d1;
	buf_ptr_t ram_dout;

	// Request payload, no reset needed.
	always_ff @(posedge clk) begin
		enq_cur_d1 <= lnk.enq_ptr_cur;
		enq_nxt_d1 <= lnk.enq_ptr_nxt;
		req_ptr_d1 <= lnk.req_ptr;
		lnk.ack_ptr <= ram_dout; // Third stage of the read path.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enq_valid_d1 <= 1'b0;
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
			lnk.ack_valid <= 1'b0;
			link_wr_count <= '0;
			link_rd_count <= '0;
		end else begin
			enq_valid_d1 <= lnk.enq_valid;
			req_d1 <= lnk.req;
			req_d2 <= req_d1;
			lnk.ack_valid <= req_d2; // Three cycles after req.
			if (enq_valid_d1) begin
				link_wr_count <= link_wr_count + 1'b1; // Committed write.
			end
			if (req_d1) begin
				link_rd_count <= link_rd_count + 1'b1; // Issued read.
			end
		end
	end

	link_ram #(
		.WIDTH(`BM_PTR_NBITS),
		.DEPTH(`BM_NUM_BUFS)
	) u_link_ram (
		.clk(clk),
		.wr(enq_valid_d1),
		.waddr(enq_cur_d1),
		.raddr(req_ptr_d1),
		.din(enq_nxt_d1),
		.dout(ram_dout)
	);

endmodule

// ==== hw/free_list.sv ====
// Free buffer pointer list
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module free_list (
	input logic clk,
	input logic rst_n,
	free_if.pool pool,
	output buf_mgr_pkg::free_cnt_t free_count
);
	import buf_mgr_pkg::*;

	buf_ptr_t fifo_mem [`BM_NUM_BUFS]; // Circular store of free pointers.
	buf_ptr_t rd_idx;
	buf_ptr_t wr_idx;
	free_cnt_t fill_cnt; // Init pointer, stops at pool size.
	logic fill_done;
	logic push;
	logic pop;
	buf_ptr_t push_ptr;

	assign fill_done = (fill_cnt == free_cnt_t'(`BM_NUM_BUFS));
	assign push = !fill_done || pool.release_valid; // Fill or release.
	assign push_ptr = fill_done ? pool.release_ptr : buf_ptr_t'(fill_cnt);
	assign pop = pool.alloc_take && pool.alloc_valid;

	// Offer only once the fill is complete.
	assign pool.alloc_valid = fill_done && (free_count != '0);
	assign pool.alloc_ptr = fifo_mem[rd_idx]; // Head of the list.

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_idx] <= push_ptr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_idx <= '0;
			wr_idx <= '0;
			fill_cnt <= '0;
			free_count <= '0;
		end else begin
			if (!fill_done) begin
				fill_cnt <= fill_cnt + 1'b1; // One pointer per cycle.
			end
			if (push) begin
				wr_idx <= wr_idx + 1'b1; // Wraps at pool size.
			end
			if (pop) begin
				rd_idx <= rd_idx + 1'b1;
			end
			case ({push, pop})
				2'b10: free_count <= free_count + 1'b1;
				2'b01: free_count <= free_count - 1'b1;
				default: free_count <= free_count; // Both or neither.
			endcase
		end
	end

endmodule

// ==== hw/queue_ctrl.sv ====
// Queue control FSM
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module queue_ctrl (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	output logic cmd_ready,
	input buf_mgr_pkg::bm_op_e cmd_op,
	input buf_mgr_pkg::qid_t cmd_qid,
	output logic rsp_valid,
	input logic rsp_ready,
	output buf_mgr_pkg::bm_status_e rsp_status,
	output buf_mgr_pkg::buf_ptr_t rsp_ptr,
	link_if.ctrl lnk,
	free_if.ctrl fl
);
	import buf_mgr_pkg::*;

	ctrl_state_e state;
	qid_t cur_qid; // Queue of the command in flight.
	buf_ptr_t new_ptr; // Pointer popped by enqueue.
	logic [1:0] hold_cnt; // Link commit delay.
	logic pool_ready; // Free list has filled once.
	logic [`BM_NUM_QUEUES-1:0] empty_q;
	buf_ptr_t head_tbl [`BM_NUM_QUEUES];
	buf_ptr_t tail_tbl [`BM_NUM_QUEUES];
	logic cmd_fire;
	logic last_buf; // Queue holds a single buffer.

	assign cmd_fire = cmd_valid && cmd_ready;
	assign last_buf = (head_tbl[cur_qid] == tail_tbl[cur_qid]);
	assign cmd_ready = (state == S_IDLE) && pool_ready;
	assign rsp_valid = (state == S_RESP) && (hold_cnt == 2'd0);

	assign fl.alloc_take = (state == S_ALLOC); // Entered only with alloc_valid.
	assign fl.release_valid = (state == S_READ); // Head goes back.
	assign fl.release_ptr = head_tbl[cur_qid];

	assign lnk.enq_valid = (state == S_LINK) && !empty_q[cur_qid]; // Old tail to new.
	assign lnk.enq_ptr_cur = tail_tbl[cur_qid];
	assign lnk.enq_ptr_nxt = new_ptr;
	assign lnk.req = (state == S_READ) && !last_buf; // Fetch next head.
	assign lnk.req_ptr = head_tbl[cur_qid];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			hold_cnt <= 2'd0;
			pool_ready <= 1'b0;
			empty_q <= '1; // All queues start empty.
		end else begin
			if (fl.alloc_valid) begin
				pool_ready <= 1'b1; // Sticky.
			end
			case (state)
				S_IDLE: begin
					if (cmd_fire && cmd_op == OP_ENQ) begin
						state <= fl.alloc_valid ? S_ALLOC : S_RESP;
					end else if (cmd_fire) begin
						state <= empty_q[cmd_qid] ? S_RESP : S_READ;
					end
				end
				S_ALLOC: state <= S_LINK;
				S_LINK: begin
					empty_q[cur_qid] <= 1'b0;
					hold_cnt <= 2'd2; // Let the link write land.
					state <= S_RESP;
				end
				S_READ: begin
					if (last_buf) begin
						empty_q[cur_qid] <= 1'b1;
						state <= S_RESP;
					end else begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (lnk.ack_valid) begin
						state <= S_RESP;
					end
				end
				S_RESP: begin
					if (hold_cnt != 2'd0) begin
						hold_cnt <= hold_cnt - 1'b1;
					end else if (rsp_ready) begin
						state <= S_IDLE; // Response taken.
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Tables and response payload.
	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (cmd_fire) begin
					cur_qid <= cmd_qid;
					rsp_ptr <= '0;
					if (cmd_op == OP_ENQ) begin
						rsp_status <= fl.alloc_valid ? ST_OK : ST_FULL;
					end else begin
						rsp_status <= empty_q[cmd_qid] ? ST_EMPTY : ST_OK;
					end
				end
			end
			S_ALLOC: new_ptr <= fl.alloc_ptr;
			S_LINK: begin
				tail_tbl[cur_qid] <= new_ptr;
				if (empty_q[cur_qid]) begin
					head_tbl[cur_qid] <= new_ptr; // First buffer in queue.
				end
				rsp_ptr <= new_ptr;
			end
			S_READ: rsp_ptr <= head_tbl[cur_qid]; // Dequeued pointer.
			S_WAIT: begin
				if (lnk.ack_valid) begin
					head_tbl[cur_qid] <= lnk.ack_ptr; // Advance head.
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hw/buf_mgr_top.sv ====
// Buffer manager top level
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module buf_mgr_top (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	output logic cmd_ready,
	input buf_mgr_pkg::bm_op_e cmd_op,
	input buf_mgr_pkg::qid_t cmd_qid,
	output logic rsp_valid,
	input logic rsp_ready,
	output buf_mgr_pkg::bm_status_e rsp_status,
	output buf_mgr_pkg::buf_ptr_t rsp_ptr,
	output buf_mgr_pkg::free_cnt_t free_count,
	output logic [`BM_COUNT_NBITS-1:0] link_wr_count,
	output logic [`BM_COUNT_NBITS-1:0] link_rd_count
);

	link_if lnk_bus (); // Control to link table.
	free_if fl_bus (); // Control to free list.

	queue_ctrl u_queue_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_op(cmd_op),
		.cmd_qid(cmd_qid),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_status(rsp_status),
		.rsp_ptr(rsp_ptr),
		.lnk(lnk_bus),
		.fl(fl_bus)
	);

	link_table u_link_table (
		.clk(clk),
		.rst_n(rst_n),
		.lnk(lnk_bus),
		.link_wr_count(link_wr_count),
		.link_rd_count(link_rd_count)
	);

	free_list u_free_list (
		.clk(clk),
		.rst_n(rst_n),
		.pool(fl_bus),
		.free_count(free_count)
	);

endmodule

// ==== bench/buf_mgr_checker.sv ====
// Buffer manager protocol assertions
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module buf_mgr_checker (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic cmd_ready,
	input logic rsp_valid,
	input logic rsp_ready,
	input buf_mgr_pkg::bm_status_e rsp_status,
	input buf_mgr_pkg::buf_ptr_t rsp_ptr,
	input buf_mgr_pkg::free_cnt_t free_count
);
	import buf_mgr_pkg::*;

	int fail_cnt = 0; // Failed assertions so far.
	logic cmd_busy; // Command accepted, response not yet taken.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_busy <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			cmd_busy <= 1'b1;
		end else if (rsp_valid && rsp_ready) begin
			cmd_busy <= 1'b0;
		end
	end

	// Response held until taken.
	assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_status) && $stable(rsp_ptr))
	else begin
		$error("response changed before rsp_ready");
		fail_cnt++;
	end

	// No new command while one is outstanding.
	assert property (@(posedge clk) disable iff (!rst_n)
		(rsp_valid || cmd_busy) |-> !cmd_ready)
	else begin
		$error("cmd_ready high during a response");
		fail_cnt++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		free_count <= free_cnt_t'(`BM_NUM_BUFS))
	else begin
		$error("free_count above pool size");
		fail_cnt++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && rsp_status == ST_OK |-> int'(rsp_ptr) < `BM_NUM_BUFS)
	else begin
		$error("rsp_ptr outside the pool");
		fail_cnt++;
	end

endmodule

bind buf_mgr_top buf_mgr_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready),
	.rsp_status(rsp_status),
	.rsp_ptr(rsp_ptr),
	.free_count(free_count)
);

// ==== bench/tb_buf_mgr.sv ====
// Buffer manager testbench
`timescale 1ns/10ps
`include "buf_mgr_cfg.svh"

module tb_buf_mgr;
	import buf_mgr_pkg::*;

	typedef logic [`BM_COUNT_NBITS-1:0] count_t;

	localparam int NUM_CMDS = 117; // All commands over all tests.
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 20 + `BM_NUM_BUFS + 16 + 8; // Plus fill and reset.

	logic clk = 1'b0;
	logic rst_n;
	logic cmd_valid;
	logic cmd_ready;
	bm_op_e cmd_op;
	qid_t cmd_qid;
	logic rsp_valid;
	logic rsp_ready;
	bm_status_e rsp_status;
	buf_ptr_t rsp_ptr;
	free_cnt_t free_count;
	count_t link_wr_count;
	count_t link_rd_count;

	integer seed = 32'h2197_baa9;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	buf_ptr_t model_free [$]; // Free pointers in pop order.
	buf_ptr_t model_q [`BM_NUM_QUEUES][$]; // Per-queue contents, head first.
	count_t exp_wr = '0;
	count_t exp_rd = '0;

	buf_mgr_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_op(cmd_op),
		.cmd_qid(cmd_qid),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_status(rsp_status),
		.rsp_ptr(rsp_ptr),
		.free_count(free_count),
		.link_wr_count(link_wr_count),
		.link_rd_count(link_rd_count)
	);

	initial begin
		forever #4 clk = ~clk; // 8 ns period.
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog timeout: response never arrived");
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic check_status(input string name, input bm_status_e got, input bm_status_e exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ptr(input string name, input buf_ptr_t got, input buf_ptr_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// Predicts one command and updates the model.
	task automatic model_cmd(input bm_op_e op, input qid_t qid,
		output bm_status_e st, output buf_ptr_t ptr);
		ptr = '0;
		if (op == OP_ENQ && model_free.size() == 0) begin
			st = ST_FULL; // Pool exhausted.
		end else if (op == OP_ENQ) begin
			st = ST_OK;
			ptr = model_free.pop_front();
			if (model_q[qid].size() != 0) begin
				exp_wr++; // Link behind old tail.
			end
			model_q[qid].push_back(ptr);
		end else if (model_q[qid].size() == 0) begin
			st = ST_EMPTY;
		end else begin
			st = ST_OK;
			if (model_q[qid].size() >= 2) begin
				exp_rd++; // Next head fetched from the link table.
			end
			ptr = model_q[qid].pop_front();
			model_free.push_back(ptr);
		end
	endtask

	// Called on a falling edge.
	task automatic send_cmd(input bm_op_e op, input qid_t qid);
		while (!cmd_ready) begin
			@(negedge clk);
		end
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_qid = qid;
		@(negedge clk); // Transfer on the edge between.
		cmd_valid = 1'b0;
	endtask

	task automatic get_rsp(input logic random_ready, output bm_status_e st, output buf_ptr_t ptr);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			rsp_ready = !random_ready || ($random(seed) % 2 == 0);
			if (rsp_valid && rsp_ready) begin
				st = rsp_status; // Taken on the next rising edge.
				ptr = rsp_ptr;
				taken = 1'b1;
			end
			@(negedge clk);
		end
		rsp_ready = 1'b0;
	endtask

	task automatic run_cmd(input bm_op_e op, input qid_t qid, input logic random_ready);
		bm_status_e got_st;
		buf_ptr_t got_ptr;
		bm_status_e exp_st;
		buf_ptr_t exp_ptr;
		send_cmd(op, qid);
		get_rsp(random_ready, got_st, got_ptr);
		model_cmd(op, qid, exp_st, exp_ptr);
		check_status("rsp_status", got_st, exp_st);
		if (exp_st == ST_OK) begin
			check_ptr("rsp_ptr", got_ptr, exp_ptr);
		end
	endtask

	task automatic check_totals();
		check_count("free_count", count_t'(free_count), count_t'(model_free.size()));
		check_count("link_wr_count", link_wr_count, exp_wr);
		check_count("link_rd_count", link_rd_count, exp_rd);
	endtask

	task automatic drain_queues();
		for (int q = 0; q < `BM_NUM_QUEUES; q++) begin
			while (model_q[q].size() != 0) begin
				run_cmd(OP_DEQ, qid_t'(q), 1'b0);
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_after_fill();
		int start_errors;
		start_errors = errors;
		while (!cmd_ready) begin
			@(negedge clk); // Free list still filling.
		end
		check_count("free_count", count_t'(free_count), count_t'(`BM_NUM_BUFS));
		check_count("link_wr_count", link_wr_count, '0);
		check_count("link_rd_count", link_rd_count, '0);
		report_test("after_fill", start_errors);
	endtask

	task automatic test_single_queue();
		int start_errors;
		start_errors = errors;
		for (int i = 0; i < 5; i++) begin
			run_cmd(OP_ENQ, '0, 1'b0); // Pointers 0 to 4.
		end
		for (int i = 0; i < 5; i++) begin
			run_cmd(OP_DEQ, '0, 1'b0);
		end
		check_count("free_count", count_t'(free_count), count_t'(`BM_NUM_BUFS));
		check_totals();
		report_test("single_queue", start_errors);
	endtask

	task automatic test_interleaved();
		int start_errors;
		start_errors = errors;
		for (int r = 0; r < 2; r++) begin
			for (int q = 0; q < `BM_NUM_QUEUES; q++) begin
				run_cmd(OP_ENQ, qid_t'(q), 1'b0);
				run_cmd(OP_ENQ, qid_t'(q), 1'b0);
			end
			for (int q = 0; q < `BM_NUM_QUEUES; q++) begin
				run_cmd(OP_DEQ, qid_t'(q), 1'b0); // One out per round.
			end
		end
		drain_queues();
		check_totals();
		report_test("interleaved", start_errors);
	endtask

	task automatic test_pool_full();
		int start_errors;
		start_errors = errors;
		for (int i = 0; i <= `BM_NUM_BUFS; i++) begin
			run_cmd(OP_ENQ, qid_t'(i), 1'b0); // Last one finds no buffer.
		end
		check_count("free_count", count_t'(free_count), '0);
		drain_queues();
		check_totals();
		report_test("pool_full", start_errors);
	endtask

	task automatic test_empty_dequeue();
		int start_errors;
		count_t free_before;
		count_t wr_before;
		count_t rd_before;
		start_errors = errors;
		free_before = count_t'(free_count);
		wr_before = link_wr_count;
		rd_before = link_rd_count;
		run_cmd(OP_DEQ, 2'd0, 1'b0);
		run_cmd(OP_DEQ, 2'd3, 1'b0);
		check_count("free_count", count_t'(free_count), free_before);
		check_count("link_wr_count", link_wr_count, wr_before);
		check_count("link_rd_count", link_rd_count, rd_before);
		report_test("empty_dequeue", start_errors);
	endtask

	task automatic test_random();
		int start_errors;
		bm_op_e op;
		qid_t qid;
		start_errors = errors;
		for (int i = 0; i < 40; i++) begin
			op = ($random(seed) % 8 < 5) ? OP_ENQ : OP_DEQ; // Slight bias to enqueue.
			qid = qid_t'($random(seed));
			run_cmd(op, qid, 1'b1);
		end
		check_totals();
		report_test("random", start_errors);
	endtask

	initial begin
		cmd_valid = 1'b0;
		cmd_op = OP_ENQ;
		cmd_qid = '0;
		rsp_ready = 1'b0;
		rst_n = 1'b0;
		for (int i = 0; i < `BM_NUM_BUFS; i++) begin
			model_free.push_back(buf_ptr_t'(i)); // Fill order of the free list.
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		test_after_fill();
		test_single_queue();
		test_interleaved();
		test_pool_full();
		test_empty_dequeue();
		test_random();
		if (UUT.u_checker.fail_cnt != 0) begin
			$display("checker reported %0d assertion failures", UUT.u_checker.fail_cnt);
			errors++;
		end
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== buf_mgr_top.f ====
+incdir+hw
hw/buf_mgr_pkg.sv
hw/buf_mgr_if.sv
hw/link_ram.sv
hw/link_table.sv
hw/free_list.sv
hw/queue_ctrl.sv
hw/buf_mgr_top.sv
bench/buf_mgr_checker.sv
bench/tb_buf_mgr.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_buf_mgr \
	-f buf_mgr_top.f -o tb_buf_mgr
./obj_dir/tb_buf_mgr | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run_sim: passed"
else
	echo "run_sim: failed"
	exit 1
fi
